//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_pu_arbitration_unit
RTL_TOP    := pu_arbitration_unit
FILELIST   := verilog.f
BUILD_DIR  := obj_dir
FLAGS      := --binary --timing -j 0 -Wno-fatal
LINT_FLAGS := --lint-only -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) \
		hw/decoder_pkg.sv hw/link_pkg.sv hw/message_fifo.sv hw/link_arbiter.sv \
		hw/link_dispatcher.sv hw/link_control.sv hw/pu_arbitration_unit.sv

clean:
	rm -rf $(BUILD_DIR)

//--- hw/decoder_pkg.sv
package decoder_pkg;

    localparam int STAGE_WIDTH = 3;

    // decoder stage as broadcast by the controller
    typedef enum logic [STAGE_WIDTH-1:0] {
        STAGE_IDLE                = 3'd0,
        STAGE_MEASUREMENT_LOADING = 3'd1,
        STAGE_GROWING             = 3'd2,
        STAGE_MERGING             = 3'd3,
        STAGE_PEELING             = 3'd4
    } stage_t;

    // one index per dimension of the 3d grid
    function automatic int address_width(input int code_distance);
        int per_dimension_width;
        per_dimension_width = $clog2(code_distance);
        return 3 * per_dimension_width;
    endfunction

endpackage

//--- hw/link_arbiter.sv
`timescale 1ns/10ps

module link_arbiter
    import link_pkg::*;
#(
    parameter int ADDRESS_WIDTH = 9
) (
    input  logic                                        clk,
    input  logic                                        reset,
    input  logic [neighbor_msg_width(ADDRESS_WIDTH)-1:0] neighbor_data_i,
    input  logic                                        neighbor_valid_i,
    output logic                                        neighbor_ready_o,
    input  logic [union_msg_width(ADDRESS_WIDTH)-1:0]    union_data_i,
    input  logic                                        union_valid_i,
    output logic                                        union_ready_o,
    input  logic [direct_msg_width(ADDRESS_WIDTH)-1:0]   direct_data_i,
    input  logic                                        direct_valid_i,
    output logic                                        direct_ready_o,
    output logic [master_data_width(ADDRESS_WIDTH)-1:0]  master_data_o,
    output logic                                        master_valid_o,
    input  logic                                        master_ready_i
);

    localparam int PAYLOAD_WIDTH = union_msg_width(ADDRESS_WIDTH);

    logic [2:0]               req;
    msg_kind_t                rr_ptr;
    msg_kind_t                grant_kind;
    logic                     grant_valid;
    logic [PAYLOAD_WIDTH-1:0] payload;

    // request bit index equals the tag value
    assign req = {direct_valid_i, union_valid_i, neighbor_valid_i};

    // walk backwards so the class closest to the pointer wins
    always_comb begin
        int cand;
        grant_valid = 1'b0;
        grant_kind  = MSG_NEIGHBOR;
        for (int off = 2; off >= 0; off--) begin
            cand = (int'(rr_ptr) + off) % 3;
            if (req[cand]) begin
                grant_valid = 1'b1;
                grant_kind  = msg_kind_t'(cand[TAG_WIDTH-1:0]);
            end
        end
    end

    always_comb begin
        case (grant_kind)
            MSG_UNION:  payload = union_data_i;
            MSG_DIRECT: payload = PAYLOAD_WIDTH'(direct_data_i);
            default:    payload = PAYLOAD_WIDTH'(neighbor_data_i);
        endcase
    end

    assign master_data_o  = {grant_kind, payload};
    assign master_valid_o = grant_valid;

    assign neighbor_ready_o = master_ready_i && grant_valid && (grant_kind == MSG_NEIGHBOR);
    assign union_ready_o    = master_ready_i && grant_valid && (grant_kind == MSG_UNION);
    assign direct_ready_o   = master_ready_i && grant_valid && (grant_kind == MSG_DIRECT);

    // pointer moves just past the class that was sent
    always_ff @(posedge clk) begin
        if (reset) begin
            rr_ptr <= MSG_NEIGHBOR;
        end else if (master_valid_o && master_ready_i) begin
            case (grant_kind)
                MSG_NEIGHBOR: rr_ptr <= MSG_UNION;
                MSG_UNION:    rr_ptr <= MSG_DIRECT;
                default:      rr_ptr <= MSG_NEIGHBOR;
            endcase
        end
    end

endmodule

//--- hw/link_control.sv
`timescale 1ns/10ps

module link_control
    import decoder_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  stage_t     stage_i,
    input  logic [5:0] occupied_i,
    input  logic       master_in_valid_i,
    output logic       flush_o,
    output logic       has_message_flying_o
);

    stage_t stage_q;

    // delayed copy stands in for the processing unit latency
    always_ff @(posedge clk) begin
        if (reset) begin
            stage_q <= STAGE_IDLE;
        end else begin
            stage_q <= stage_i;
        end
    end

    // channels are cleared while new measurements load
    assign flush_o = (stage_q == STAGE_MEASUREMENT_LOADING);

    always_ff @(posedge clk) begin
        if (reset) begin
            has_message_flying_o <= 1'b0;
        end else begin
            has_message_flying_o <= (|occupied_i) || master_in_valid_i;
        end
    end

endmodule

//--- hw/link_dispatcher.sv
`timescale 1ns/10ps

module link_dispatcher
    import link_pkg::*;
#(
    parameter int ADDRESS_WIDTH = 9
) (
    input  logic [master_data_width(ADDRESS_WIDTH)-1:0]  master_data_i,
    input  logic                                        master_valid_i,
    output logic                                        master_ready_o,
    output logic [neighbor_msg_width(ADDRESS_WIDTH)-1:0] neighbor_data_o,
    output logic                                        neighbor_valid_o,
    input  logic                                        neighbor_ready_i,
    output logic [union_msg_width(ADDRESS_WIDTH)-1:0]    union_data_o,
    output logic                                        union_valid_o,
    input  logic                                        union_ready_i,
    output logic [direct_msg_width(ADDRESS_WIDTH)-1:0]   direct_data_o,
    output logic                                        direct_valid_o,
    input  logic                                        direct_ready_i
);

    localparam int MASTER_WIDTH = master_data_width(ADDRESS_WIDTH);

    msg_kind_t kind;

    assign kind = msg_kind_t'(master_data_i[MASTER_WIDTH-1 -: TAG_WIDTH]);

    // payloads are right aligned under the tag
    assign neighbor_data_o = master_data_i[neighbor_msg_width(ADDRESS_WIDTH)-1:0];
    assign union_data_o    = master_data_i[union_msg_width(ADDRESS_WIDTH)-1:0];
    assign direct_data_o   = master_data_i[direct_msg_width(ADDRESS_WIDTH)-1:0];

    assign neighbor_valid_o = master_valid_i && (kind == MSG_NEIGHBOR);
    assign union_valid_o    = master_valid_i && (kind == MSG_UNION);
    assign direct_valid_o   = master_valid_i && (kind == MSG_DIRECT);

    always_comb begin
        case (kind)
            MSG_NEIGHBOR: master_ready_o = neighbor_ready_i;
            MSG_UNION:    master_ready_o = union_ready_i;
            MSG_DIRECT:   master_ready_o = direct_ready_i;
            // reserved words are swallowed
            default:      master_ready_o = 1'b1;
        endcase
    end

endmodule

//--- hw/link_pkg.sv
package link_pkg;

    localparam int TAG_WIDTH = 2;

    // tag in the top bits of every master word
    typedef enum logic [TAG_WIDTH-1:0] {
        MSG_NEIGHBOR = 2'd0,
        MSG_UNION    = 2'd1,
        MSG_DIRECT   = 2'd2,
        MSG_RESERVED = 2'd3
    } msg_kind_t;

    // old root plus grown flag
    function automatic int neighbor_msg_width(input int address_width);
        return address_width + 1;
    endfunction

    // old root and updated root
    function automatic int union_msg_width(input int address_width);
        return 2 * address_width;
    endfunction

    // receiver, odd cardinality, touching boundary
    function automatic int direct_msg_width(input int address_width);
        return address_width + 2;
    endfunction

    // union is the widest payload, the others are padded up to it
    function automatic int master_data_width(input int address_width);
        return union_msg_width(address_width) + TAG_WIDTH;
    endfunction

endpackage

//--- hw/message_fifo.sv
`timescale 1ns/10ps

module message_fifo #(
    parameter int  DEPTH     = 4,
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     flush_i,
    input  payload_t data_i,
    input  logic     valid_i,
    output logic     ready_o,
    output payload_t data_o,
    output logic     valid_o,
    input  logic     ready_i,
    output logic     occupied_o
);

    localparam int PTR_WIDTH   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int COUNT_WIDTH = $clog2(DEPTH + 1);

    payload_t               mem [DEPTH];
    logic [PTR_WIDTH-1:0]   wr_ptr;
    logic [PTR_WIDTH-1:0]   rd_ptr;
    logic [COUNT_WIDTH-1:0] count;
    logic                   push;
    logic                   pop;

    // flush holds both sides off
    assign ready_o    = (count != COUNT_WIDTH'(DEPTH)) && !flush_i;
    assign valid_o    = (count != '0) && !flush_i;
    assign occupied_o = (count != '0);
    assign data_o     = mem[rd_ptr];

    assign push = valid_i && ready_o;
    assign pop  = valid_o && ready_i;

    always_ff @(posedge clk) begin
        if (reset || flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= data_i;
        end
    end

endmodule

//--- hw/pu_arbitration_unit.sv
`timescale 1ns/10ps

module pu_arbitration_unit
    import decoder_pkg::*;
    import link_pkg::*;
#(
    parameter int   CODE_DISTANCE = 5,
    parameter int   FIFO_DEPTH    = 4,
    localparam int  ADDRESS_WIDTH = address_width(CODE_DISTANCE)
) (
    input  logic                                        clk,
    input  logic                                        reset,
    input  logic [STAGE_WIDTH-1:0]                      stage_i,
    input  logic [neighbor_msg_width(ADDRESS_WIDTH)-1:0] neighbor_tx_data_i,
    input  logic                                        neighbor_tx_valid_i,
    output logic                                        neighbor_tx_ready_o,
    input  logic [union_msg_width(ADDRESS_WIDTH)-1:0]    union_tx_data_i,
    input  logic                                        union_tx_valid_i,
    output logic                                        union_tx_ready_o,
    input  logic [direct_msg_width(ADDRESS_WIDTH)-1:0]   direct_tx_data_i,
    input  logic                                        direct_tx_valid_i,
    output logic                                        direct_tx_ready_o,
    output logic [neighbor_msg_width(ADDRESS_WIDTH)-1:0] neighbor_rx_data_o,
    output logic                                        neighbor_rx_valid_o,
    input  logic                                        neighbor_rx_ready_i,
    output logic [union_msg_width(ADDRESS_WIDTH)-1:0]    union_rx_data_o,
    output logic                                        union_rx_valid_o,
    input  logic                                        union_rx_ready_i,
    output logic [direct_msg_width(ADDRESS_WIDTH)-1:0]   direct_rx_data_o,
    output logic                                        direct_rx_valid_o,
    input  logic                                        direct_rx_ready_i,
    output logic [master_data_width(ADDRESS_WIDTH)-1:0]  master_out_data_o,
    output logic                                        master_out_valid_o,
    input  logic                                        master_out_ready_i,
    input  logic [master_data_width(ADDRESS_WIDTH)-1:0]  master_in_data_i,
    input  logic                                        master_in_valid_i,
    output logic                                        master_in_ready_o,
    output logic                                        has_message_flying_o
);

    typedef logic [neighbor_msg_width(ADDRESS_WIDTH)-1:0] neighbor_msg_t;
    typedef logic [union_msg_width(ADDRESS_WIDTH)-1:0]    union_msg_t;
    typedef logic [direct_msg_width(ADDRESS_WIDTH)-1:0]   direct_msg_t;

    // egress heads towards the arbiter
    neighbor_msg_t neighbor_eg_data;
    logic          neighbor_eg_valid;
    logic          neighbor_eg_ready;
    union_msg_t    union_eg_data;
    logic          union_eg_valid;
    logic          union_eg_ready;
    direct_msg_t   direct_eg_data;
    logic          direct_eg_valid;
    logic          direct_eg_ready;

    // dispatcher outputs into the ingress queues
    neighbor_msg_t neighbor_in_data;
    logic          neighbor_in_valid;
    logic          neighbor_in_ready;
    union_msg_t    union_in_data;
    logic          union_in_valid;
    logic          union_in_ready;
    direct_msg_t   direct_in_data;
    logic          direct_in_valid;
    logic          direct_in_ready;

    // [2:0] egress, [5:3] ingress, neighbor first
    logic [5:0] occupied;
    logic       flush;

    message_fifo #(.DEPTH(FIFO_DEPTH), .payload_t(neighbor_msg_t)) i_neighbor_tx_fifo (
        .clk(clk), .reset(reset), .flush_i(flush),
        .data_i(neighbor_tx_data_i), .valid_i(neighbor_tx_valid_i),
        .ready_o(neighbor_tx_ready_o),
        .data_o(neighbor_eg_data), .valid_o(neighbor_eg_valid), .ready_i(neighbor_eg_ready),
        .occupied_o(occupied[0])
    );

    message_fifo #(.DEPTH(FIFO_DEPTH), .payload_t(union_msg_t)) i_union_tx_fifo (
        .clk(clk), .reset(reset), .flush_i(flush),
        .data_i(union_tx_data_i), .valid_i(union_tx_valid_i), .ready_o(union_tx_ready_o),
        .data_o(union_eg_data), .valid_o(union_eg_valid), .ready_i(union_eg_ready),
        .occupied_o(occupied[1])
    );

    message_fifo #(.DEPTH(FIFO_DEPTH), .payload_t(direct_msg_t)) i_direct_tx_fifo (
        .clk(clk), .reset(reset), .flush_i(flush),
        .data_i(direct_tx_data_i), .valid_i(direct_tx_valid_i), .ready_o(direct_tx_ready_o),
        .data_o(direct_eg_data), .valid_o(direct_eg_valid), .ready_i(direct_eg_ready),
        .occupied_o(occupied[2])
    );

    link_arbiter #(.ADDRESS_WIDTH(ADDRESS_WIDTH)) i_link_arbiter (
        .clk(clk), .reset(reset),
        .neighbor_data_i(neighbor_eg_data), .neighbor_valid_i(neighbor_eg_valid),
        .neighbor_ready_o(neighbor_eg_ready),
        .union_data_i(union_eg_data), .union_valid_i(union_eg_valid),
        .union_ready_o(union_eg_ready),
        .direct_data_i(direct_eg_data), .direct_valid_i(direct_eg_valid),
        .direct_ready_o(direct_eg_ready),
        .master_data_o(master_out_data_o), .master_valid_o(master_out_valid_o),
        .master_ready_i(master_out_ready_i)
    );

    link_dispatcher #(.ADDRESS_WIDTH(ADDRESS_WIDTH)) i_link_dispatcher (
        .master_data_i(master_in_data_i), .master_valid_i(master_in_valid_i),
        .master_ready_o(master_in_ready_o),
        .neighbor_data_o(neighbor_in_data), .neighbor_valid_o(neighbor_in_valid),
        .neighbor_ready_i(neighbor_in_ready),
        .union_data_o(union_in_data), .union_valid_o(union_in_valid),
        .union_ready_i(union_in_ready),
        .direct_data_o(direct_in_data), .direct_valid_o(direct_in_valid),
        .direct_ready_i(direct_in_ready)
    );

    message_fifo #(.DEPTH(FIFO_DEPTH), .payload_t(neighbor_msg_t)) i_neighbor_rx_fifo (
        .clk(clk), .reset(reset), .flush_i(flush),
        .data_i(neighbor_in_data), .valid_i(neighbor_in_valid), .ready_o(neighbor_in_ready),
        .data_o(neighbor_rx_data_o), .valid_o(neighbor_rx_valid_o),
        .ready_i(neighbor_rx_ready_i),
        .occupied_o(occupied[3])
    );

    message_fifo #(.DEPTH(FIFO_DEPTH), .payload_t(union_msg_t)) i_union_rx_fifo (
        .clk(clk), .reset(reset), .flush_i(flush),
        .data_i(union_in_data), .valid_i(union_in_valid), .ready_o(union_in_ready),
        .data_o(union_rx_data_o), .valid_o(union_rx_valid_o), .ready_i(union_rx_ready_i),
        .occupied_o(occupied[4])
    );

    message_fifo #(.DEPTH(FIFO_DEPTH), .payload_t(direct_msg_t)) i_direct_rx_fifo (
        .clk(clk), .reset(reset), .flush_i(flush),
        .data_i(direct_in_data), .valid_i(direct_in_valid), .ready_o(direct_in_ready),
        .data_o(direct_rx_data_o), .valid_o(direct_rx_valid_o), .ready_i(direct_rx_ready_i),
        .occupied_o(occupied[5])
    );

    link_control i_link_control (
        .clk(clk),
        .reset(reset),
        .stage_i(stage_t'(stage_i)),
        .occupied_i(occupied),
        .master_in_valid_i(master_in_valid_i),
        .flush_o(flush),
        .has_message_flying_o(has_message_flying_o)
    );

endmodule

//--- tb/tb_clock.sv
`timescale 1ns/10ps

module tb_clock #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // synchronous reset released on a rising edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

//--- tb/tb_pu_arbitration_unit.sv
`timescale 1ns/10ps

module tb_pu_arbitration_unit
    import decoder_pkg::*;
    import link_pkg::*;
();

    localparam int CODE_DISTANCE   = 5;
    localparam int FIFO_DEPTH      = 4;
    localparam int AW              = address_width(CODE_DISTANCE);
    localparam int NW              = neighbor_msg_width(AW);
    localparam int UW              = union_msg_width(AW);
    localparam int DW              = direct_msg_width(AW);
    localparam int MW              = master_data_width(AW);
    localparam int PW              = union_msg_width(AW);
    localparam int TRAFFIC_CYCLES  = 400;
    localparam int FAIRNESS_CYCLES = 60;
    localparam int STALL_CYCLES    = 8;
    // four words per cycle at most while traffic runs
    localparam int MAX_MESSAGES    = 2 * 4 * TRAFFIC_CYCLES + 3 * FAIRNESS_CYCLES
                                     + 4 * STALL_CYCLES;
    localparam int TIMEOUT_NS      = (20 * MAX_MESSAGES + 500) * 8;

    logic clk;
    logic reset;
    logic [STAGE_WIDTH-1:0] stage;
    logic [NW-1:0] neighbor_tx_data, neighbor_rx_data;
    logic [UW-1:0] union_tx_data, union_rx_data;
    logic [DW-1:0] direct_tx_data, direct_rx_data;
    logic neighbor_tx_valid, neighbor_tx_ready, neighbor_rx_valid, neighbor_rx_ready;
    logic union_tx_valid, union_tx_ready, union_rx_valid, union_rx_ready;
    logic direct_tx_valid, direct_tx_ready, direct_rx_valid, direct_rx_ready;
    logic [MW-1:0] master_out_data, master_in_data;
    logic master_out_valid, master_out_ready, master_in_valid, master_in_ready;
    logic has_message_flying;

    // reference queues hold payloads zero extended to the union width
    logic [PW-1:0] tx_neighbor_q[$], tx_union_q[$], tx_direct_q[$];
    logic [PW-1:0] rx_neighbor_q[$], rx_union_q[$], rx_direct_q[$];

    logic [31:0] lcg_state = 32'h3a2d2e00;
    int          errors    = 0;
    int          checks    = 0;
    bit          fairness_on = 1'b0;
    bit          last_grant_valid = 1'b0;
    logic [1:0]  last_grant;

    tb_clock #(.PERIOD_NS(8), .RESET_CYCLES(4)) i_tb_clock (.clk(clk), .reset(reset));

    pu_arbitration_unit #(.CODE_DISTANCE(CODE_DISTANCE), .FIFO_DEPTH(FIFO_DEPTH))
    i_pu_arbitration_unit (
        .clk(clk), .reset(reset), .stage_i(stage),
        .neighbor_tx_data_i(neighbor_tx_data), .neighbor_tx_valid_i(neighbor_tx_valid),
        .neighbor_tx_ready_o(neighbor_tx_ready),
        .union_tx_data_i(union_tx_data), .union_tx_valid_i(union_tx_valid),
        .union_tx_ready_o(union_tx_ready),
        .direct_tx_data_i(direct_tx_data), .direct_tx_valid_i(direct_tx_valid),
        .direct_tx_ready_o(direct_tx_ready),
        .neighbor_rx_data_o(neighbor_rx_data), .neighbor_rx_valid_o(neighbor_rx_valid),
        .neighbor_rx_ready_i(neighbor_rx_ready),
        .union_rx_data_o(union_rx_data), .union_rx_valid_o(union_rx_valid),
        .union_rx_ready_i(union_rx_ready),
        .direct_rx_data_o(direct_rx_data), .direct_rx_valid_o(direct_rx_valid),
        .direct_rx_ready_i(direct_rx_ready),
        .master_out_data_o(master_out_data), .master_out_valid_o(master_out_valid),
        .master_out_ready_i(master_out_ready),
        .master_in_data_i(master_in_data), .master_in_valid_i(master_in_valid),
        .master_in_ready_o(master_in_ready),
        .has_message_flying_o(has_message_flying)
    );

    // low bits of an lcg are weak, so two steps give one word of high halves
    function automatic logic [31:0] next_random();
        logic [31:0] first;
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        first     = lcg_state;
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {first[31:16], lcg_state[31:16]};
    endfunction

    function automatic logic [MW-1:0] make_master_word(input logic [1:0] tag,
                                                       input logic [31:0] bits);
        case (tag)
            2'd0:    return {tag, PW'(bits[NW-1:0])};
            2'd2:    return {tag, PW'(bits[DW-1:0])};
            default: return {tag, bits[PW-1:0]};
        endcase
    endfunction

    function automatic logic [1:0] following_class(input logic [1:0] kind);
        case (kind)
            2'd0:    return 2'd1;
            2'd1:    return 2'd2;
            default: return 2'd0;
        endcase
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] exp,
                                   input logic [31:0] got);
        errors++;
        $display("Mismatch at %0t ns: %s, expected %h, got %h", $time, what, exp, got);
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("Error at %0t ns: %s", $time, msg);
    endtask

    task automatic check_head(ref logic [PW-1:0] q[$], input logic [PW-1:0] got,
                              input string what);
        logic [PW-1:0] exp;
        checks++;
        if (q.size() == 0) begin
            report_error({what, " word arrived with nothing pending"});
        end else begin
            exp = q.pop_front();
            if (exp != got) begin
                report_mismatch(what, 32'(exp), 32'(got));
            end
        end
    endtask

    task automatic check_master_out();
        logic [1:0] tag;
        tag = master_out_data[MW-1 -: TAG_WIDTH];
        case (tag)
            2'd0:    check_head(tx_neighbor_q, master_out_data[PW-1:0], "master out neighbor");
            2'd1:    check_head(tx_union_q, master_out_data[PW-1:0], "master out union");
            2'd2:    check_head(tx_direct_q, master_out_data[PW-1:0], "master out direct");
            default: report_error("master out carried the reserved tag");
        endcase
        if (fairness_on) begin
            checks++;
            if (last_grant_valid && tag != following_class(last_grant)) begin
                report_mismatch("round robin grant order", 32'(following_class(last_grant)),
                                32'(tag));
            end
        end
        last_grant       = tag;
        last_grant_valid = 1'b1;
    endtask

    // model update and output checks on values held before the edge
    always @(posedge clk) begin
        if (!reset) begin
            if (neighbor_tx_valid && neighbor_tx_ready)
                tx_neighbor_q.push_back(PW'(neighbor_tx_data));
            if (union_tx_valid && union_tx_ready)
                tx_union_q.push_back(PW'(union_tx_data));
            if (direct_tx_valid && direct_tx_ready)
                tx_direct_q.push_back(PW'(direct_tx_data));
            if (master_in_valid && master_in_ready) begin
                case (master_in_data[MW-1 -: TAG_WIDTH])
                    2'd0: rx_neighbor_q.push_back(PW'(master_in_data[NW-1:0]));
                    2'd1: rx_union_q.push_back(master_in_data[PW-1:0]);
                    2'd2: rx_direct_q.push_back(PW'(master_in_data[DW-1:0]));
                    default: ;
                endcase
            end
            if (master_out_valid && master_out_ready) check_master_out();
            if (neighbor_rx_valid && neighbor_rx_ready)
                check_head(rx_neighbor_q, PW'(neighbor_rx_data), "neighbor rx");
            if (union_rx_valid && union_rx_ready)
                check_head(rx_union_q, union_rx_data, "union rx");
            if (direct_rx_valid && direct_rx_ready)
                check_head(rx_direct_q, PW'(direct_rx_data), "direct rx");
        end
    end

    // ready_mode 0 stalls all outputs, 1 is random, 2 always ready
    task automatic drive_cycle(input bit send_tx, input bit send_in, input int ready_mode);
        logic [31:0] r;
        @(posedge clk);
        r = next_random();
        // a raised valid keeps its word until the transfer
        if (!neighbor_tx_valid || neighbor_tx_ready) begin
            neighbor_tx_valid <= send_tx && (r[0] || ready_mode == 2);
            neighbor_tx_data  <= NW'(next_random());
        end
        if (!union_tx_valid || union_tx_ready) begin
            union_tx_valid <= send_tx && (r[1] || ready_mode == 2);
            union_tx_data  <= UW'(next_random());
        end
        if (!direct_tx_valid || direct_tx_ready) begin
            direct_tx_valid <= send_tx && (r[2] || ready_mode == 2);
            direct_tx_data  <= DW'(next_random());
        end
        if (!master_in_valid || master_in_ready) begin
            master_in_valid <= send_in && r[3];
            master_in_data  <= make_master_word(r[5:4], next_random());
        end
        master_out_ready  <= (ready_mode == 2) || (ready_mode == 1 && r[6]);
        neighbor_rx_ready <= (ready_mode == 2) || (ready_mode == 1 && r[7]);
        union_rx_ready    <= (ready_mode == 2) || (ready_mode == 1 && r[8]);
        direct_rx_ready   <= (ready_mode == 2) || (ready_mode == 1 && r[9]);
    endtask

    task automatic drain_and_check();
        do begin
            drive_cycle(1'b0, 1'b0, 2);
            @(negedge clk);
        end while (tx_neighbor_q.size() + tx_union_q.size() + tx_direct_q.size()
                   + rx_neighbor_q.size() + rx_union_q.size() + rx_direct_q.size() != 0
                   || neighbor_tx_valid || union_tx_valid || direct_tx_valid
                   || master_in_valid);
        @(negedge clk);
        checks++;
        if (master_out_valid || neighbor_rx_valid || union_rx_valid || direct_rx_valid) begin
            report_error("a valid output stayed high after all messages were delivered");
        end
    endtask

    task automatic run_traffic();
        repeat (TRAFFIC_CYCLES) drive_cycle(1'b1, 1'b1, 1);
        drain_and_check();
    endtask

    initial begin
        stage = STAGE_IDLE;
        neighbor_tx_data = '0;
        neighbor_tx_valid = 1'b0;
        union_tx_data = '0;
        union_tx_valid = 1'b0;
        direct_tx_data = '0;
        direct_tx_valid = 1'b0;
        neighbor_rx_ready = 1'b0;
        union_rx_ready = 1'b0;
        direct_rx_ready = 1'b0;
        master_out_ready = 1'b0;
        master_in_data = '0;
        master_in_valid = 1'b0;

        @(negedge clk);
        while (reset) @(negedge clk);
        checks++;
        if (neighbor_rx_valid || union_rx_valid || direct_rx_valid || master_out_valid
            || has_message_flying || !neighbor_tx_ready || !union_tx_ready
            || !direct_tx_ready) begin
            report_error("outputs are not in their reset state");
        end

        run_traffic();

        // all classes stay requested so grants must rotate
        repeat (8) drive_cycle(1'b1, 1'b0, 2);
        @(negedge clk);
        fairness_on      = 1'b1;
        last_grant_valid = 1'b0;
        repeat (FAIRNESS_CYCLES) drive_cycle(1'b1, 1'b0, 2);
        @(negedge clk);
        fairness_on = 1'b0;
        drain_and_check();

        // fill the queues with every output stalled
        repeat (STALL_CYCLES) drive_cycle(1'b1, 1'b1, 0);
        @(posedge clk);
        neighbor_tx_valid <= 1'b0;
        union_tx_valid    <= 1'b0;
        direct_tx_valid   <= 1'b0;
        master_in_valid   <= 1'b0;
        repeat (2) @(negedge clk);
        checks++;
        if (!has_message_flying) begin
            report_error("message flying flag is low while queues hold words");
        end
        @(posedge clk);
        stage <= STAGE_MEASUREMENT_LOADING;
        @(negedge clk);
        tx_neighbor_q.delete();
        tx_union_q.delete();
        tx_direct_q.delete();
        rx_neighbor_q.delete();
        rx_union_q.delete();
        rx_direct_q.delete();
        @(negedge clk);
        checks++;
        if (master_out_valid || neighbor_rx_valid || union_rx_valid || direct_rx_valid) begin
            report_error("a valid output stayed high during the flush");
        end
        // measurement loading is held for three cycles in all
        repeat (2) @(posedge clk);
        stage <= STAGE_IDLE;
        repeat (2) @(posedge clk);
        @(negedge clk);
        checks++;
        if (master_out_valid || neighbor_rx_valid || union_rx_valid || direct_rx_valid) begin
            report_error("a valid output was high after the flush");
        end
        checks++;
        if (has_message_flying) begin
            report_error("message flying flag stayed high after the flush");
        end

        run_traffic();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

//--- verilog.f
hw/decoder_pkg.sv
hw/link_pkg.sv
hw/message_fifo.sv
hw/link_arbiter.sv
hw/link_dispatcher.sv
hw/link_control.sv
hw/pu_arbitration_unit.sv
tb/tb_clock.sv
tb/tb_pu_arbitration_unit.sv
